// ==== design/rv32i_pkg.sv ====
package rv32i_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;

    // major opcodes handled by this core
    typedef enum logic [6:0] {
        op_lui   = 7'b0110111,
        op_auipc = 7'b0010111,
        op_jal   = 7'b1101111,
        op_jalr  = 7'b1100111,
        op_br    = 7'b1100011,
        op_imm   = 7'b0010011,
        op_reg   = 7'b0110011
    } opcode_t;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_srl,
        alu_sra,
        alu_or,
        alu_and
    } alu_op_t;

    // encoded exactly as funct3 of the branch
    typedef enum logic [2:0] {
        cmp_beq  = 3'b000,
        cmp_bne  = 3'b001,
        cmp_blt  = 3'b100,
        cmp_bge  = 3'b101,
        cmp_bltu = 3'b110,
        cmp_bgeu = 3'b111
    } cmp_op_t;

    typedef enum logic [1:0] {sel_a_rs1, sel_a_pc, sel_a_zero} op_a_sel_t;
    typedef enum logic {sel_b_rs2, sel_b_imm} op_b_sel_t;
    typedef enum logic {wb_alu, wb_pc4} wb_sel_t;
    typedef enum logic [1:0] {fwd_reg, fwd_mem, fwd_wb} fwd_sel_t;

    typedef struct packed {
        reg_idx_t  rs1;
        reg_idx_t  rs2;
        reg_idx_t  rd;
        word_t     imm;
        alu_op_t   alu_op;
        cmp_op_t   cmp_op;
        op_a_sel_t op_a_sel;
        op_b_sel_t op_b_sel;
        wb_sel_t   wb_sel;
        logic      reg_write;
        logic      is_branch;
        logic      is_jal;
        logic      is_jalr;
    } decoded_t;

    // addi x0, x0, 0
    localparam word_t NOP_INSTR = 32'h0000_0013;

endpackage

// ==== design/rv32i_decoder.sv ====
`timescale 1ns/1ps

module rv32i_decoder (
    input  rv32i_pkg::word_t    instr_i,
    output rv32i_pkg::decoded_t decoded_o
);
    import rv32i_pkg::*;

    word_t i_imm;
    word_t b_imm;
    word_t u_imm;
    word_t j_imm;
    logic  alt;

    // funct3 plus the bit-30 variant to alu op
    function automatic alu_op_t alu_fn(input logic [2:0] f3, input logic sel_alt);
        case (f3)
            3'b000:  return sel_alt ? alu_sub : alu_add;
            3'b001:  return alu_sll;
            3'b010:  return alu_slt;
            3'b011:  return alu_sltu;
            3'b100:  return alu_xor;
            3'b101:  return sel_alt ? alu_sra : alu_srl;
            3'b110:  return alu_or;
            default: return alu_and;
        endcase
    endfunction

    // immediate formats, all sign extended from bit 31
    assign i_imm = {{20{instr_i[31]}}, instr_i[31:20]};
    assign b_imm = {{20{instr_i[31]}}, instr_i[7], instr_i[30:25], instr_i[11:8], 1'b0};
    assign u_imm = {instr_i[31:12], 12'b0};
    assign j_imm = {{12{instr_i[31]}}, instr_i[19:12], instr_i[20], instr_i[30:21], 1'b0};
    assign alt   = instr_i[30];

    always_comb begin
        decoded_o           = '0;
        decoded_o.rs1       = instr_i[19:15];
        decoded_o.rs2       = instr_i[24:20];
        decoded_o.rd        = instr_i[11:7];
        decoded_o.alu_op    = alu_add;
        decoded_o.cmp_op    = cmp_op_t'(instr_i[14:12]);
        decoded_o.op_a_sel  = sel_a_rs1;
        decoded_o.op_b_sel  = sel_b_imm;
        decoded_o.wb_sel    = wb_alu;
        decoded_o.reg_write = 1'b1;
        case (instr_i[6:0])
            op_lui: begin
                decoded_o.imm      = u_imm;
                decoded_o.op_a_sel = sel_a_zero;
            end
            op_auipc: begin
                decoded_o.imm      = u_imm;
                decoded_o.op_a_sel = sel_a_pc;
            end
            op_jal: begin
                decoded_o.imm    = j_imm;
                decoded_o.wb_sel = wb_pc4;
                decoded_o.is_jal = 1'b1;
            end
            op_jalr: begin
                decoded_o.imm     = i_imm;
                decoded_o.wb_sel  = wb_pc4;
                decoded_o.is_jalr = 1'b1;
            end
            op_br: begin
                // rd zeroed so nothing ever forwards from a branch
                decoded_o.imm       = b_imm;
                decoded_o.rd        = '0;
                decoded_o.op_b_sel  = sel_b_rs2;
                decoded_o.is_branch = 1'b1;
                decoded_o.reg_write = 1'b0;
            end
            op_imm: begin
                decoded_o.imm    = i_imm;
                // only srai uses bit 30, addi keeps it as immediate
                decoded_o.alu_op = alu_fn(instr_i[14:12], alt && instr_i[14:12] == 3'b101);
            end
            op_reg: begin
                decoded_o.op_b_sel = sel_b_rs2;
                decoded_o.alu_op   = alu_fn(instr_i[14:12], alt);
            end
            default: begin
                // unknown opcode behaves like addi x0, x0, 0
                decoded_o.rs1       = '0;
                decoded_o.rs2       = '0;
                decoded_o.rd        = '0;
                decoded_o.reg_write = 1'b0;
            end
        endcase
        // writes to x0 are dropped here once
        if (decoded_o.rd == '0) begin
            decoded_o.reg_write = 1'b0;
        end
    end

endmodule

// ==== design/rv32i_regfile.sv ====
`timescale 1ns/1ps

module rv32i_regfile (
    input  logic                clk,
    input  logic                reset_i,
    input  logic                we_i,
    input  rv32i_pkg::reg_idx_t waddr_i,
    input  rv32i_pkg::word_t    wdata_i,
    input  rv32i_pkg::reg_idx_t raddr_a_i,
    input  rv32i_pkg::reg_idx_t raddr_b_i,
    output rv32i_pkg::word_t    rdata_a_o,
    output rv32i_pkg::word_t    rdata_b_o
);
    import rv32i_pkg::*;

    word_t regs [32];
    logic  wr_en;

    // x0 stays zero
    assign wr_en = we_i && waddr_i != '0;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    // same-cycle write passes straight through to readers in ID
    assign rdata_a_o = (wr_en && waddr_i == raddr_a_i) ? wdata_i : regs[raddr_a_i];
    assign rdata_b_o = (wr_en && waddr_i == raddr_b_i) ? wdata_i : regs[raddr_b_i];

endmodule

// ==== design/rv32i_alu.sv ====
`timescale 1ns/1ps

module rv32i_alu (
    input  rv32i_pkg::decoded_t decoded_i,
    input  rv32i_pkg::word_t    pc_i,
    input  rv32i_pkg::word_t    op1_i,
    input  rv32i_pkg::word_t    op2_i,
    output rv32i_pkg::word_t    result_o,
    output rv32i_pkg::word_t    target_o,
    output logic                redirect_o
);
    import rv32i_pkg::*;

    word_t a;
    word_t b;
    word_t base;
    word_t sum;
    logic  taken;

    // operand muxes
    always_comb begin
        case (decoded_i.op_a_sel)
            sel_a_pc:   a = pc_i;
            sel_a_zero: a = '0;
            default:    a = op1_i;
        endcase
        b = (decoded_i.op_b_sel == sel_b_rs2) ? op2_i : decoded_i.imm;
    end

    always_comb begin
        case (decoded_i.alu_op)
            alu_sub:  result_o = a - b;
            alu_sll:  result_o = a << b[4:0];
            alu_slt:  result_o = {31'b0, $signed(a) < $signed(b)};
            alu_sltu: result_o = {31'b0, a < b};
            alu_xor:  result_o = a ^ b;
            alu_srl:  result_o = a >> b[4:0];
            alu_sra:  result_o = $signed(a) >>> b[4:0];
            alu_or:   result_o = a | b;
            alu_and:  result_o = a & b;
            default:  result_o = a + b;
        endcase
    end

    // branch compare on the forwarded register values
    always_comb begin
        case (decoded_i.cmp_op)
            cmp_beq:  taken = op1_i == op2_i;
            cmp_bne:  taken = op1_i != op2_i;
            cmp_blt:  taken = $signed(op1_i) < $signed(op2_i);
            cmp_bge:  taken = $signed(op1_i) >= $signed(op2_i);
            cmp_bltu: taken = op1_i < op2_i;
            cmp_bgeu: taken = op1_i >= op2_i;
            default:  taken = 1'b0;
        endcase
    end

    // jalr is relative to rs1, everything else to pc
    assign base       = decoded_i.is_jalr ? op1_i : pc_i;
    assign sum        = base + decoded_i.imm;
    assign target_o   = {sum[31:1], sum[0] & ~decoded_i.is_jalr};
    assign redirect_o = (decoded_i.is_branch && taken) || decoded_i.is_jal || decoded_i.is_jalr;

endmodule

// ==== design/rv32i_forward.sv ====
`timescale 1ns/1ps

module rv32i_forward (
    input  rv32i_pkg::reg_idx_t ex_rs1_i,
    input  rv32i_pkg::reg_idx_t ex_rs2_i,
    input  rv32i_pkg::word_t    rs1_val_i,
    input  rv32i_pkg::word_t    rs2_val_i,
    input  rv32i_pkg::reg_idx_t mem_rd_i,
    input  logic                mem_write_i,
    input  rv32i_pkg::word_t    mem_result_i,
    input  rv32i_pkg::reg_idx_t wb_rd_i,
    input  logic                wb_write_i,
    input  rv32i_pkg::word_t    wb_result_i,
    output rv32i_pkg::word_t    op1_o,
    output rv32i_pkg::word_t    op2_o
);
    import rv32i_pkg::*;

    fwd_sel_t sel1;
    fwd_sel_t sel2;

    // younger producer in MEM takes priority over WB
    function automatic fwd_sel_t pick(input reg_idx_t rs);
        if (rs == '0) begin
            return fwd_reg;
        end
        if (mem_write_i && mem_rd_i == rs) begin
            return fwd_mem;
        end
        if (wb_write_i && wb_rd_i == rs) begin
            return fwd_wb;
        end
        return fwd_reg;
    endfunction

    function automatic word_t mux(input fwd_sel_t sel, input word_t reg_val);
        case (sel)
            fwd_mem: return mem_result_i;
            fwd_wb:  return wb_result_i;
            default: return reg_val;
        endcase
    endfunction

    assign sel1  = pick(ex_rs1_i);
    assign sel2  = pick(ex_rs2_i);
    assign op1_o = mux(sel1, rs1_val_i);
    assign op2_o = mux(sel2, rs2_val_i);

endmodule

// ==== design/rv32i_pc_control.sv ====
`timescale 1ns/1ps

module rv32i_pc_control #(
    parameter rv32i_pkg::word_t RESET_PC = '0
) (
    input  logic             clk,
    input  logic             reset_i,
    input  logic             advance_i,
    input  logic             redirect_i,
    input  rv32i_pkg::word_t target_i,
    output rv32i_pkg::word_t pc_o,
    output logic             flush_o
);
    import rv32i_pkg::*;

    word_t pc_q;
    word_t pc_next;

    // target already has bit 0 cleared for jalr
    assign pc_next = redirect_i ? target_i : pc_q + 32'd4;

    // pc only moves on an accepted fetch
    always_ff @(posedge clk) begin
        if (reset_i) begin
            pc_q <= RESET_PC;
        end else if (advance_i) begin
            pc_q <= pc_next;
        end
    end

    assign pc_o = pc_q;

    // the two younger slots die on the same edge the target loads
    assign flush_o = redirect_i;

endmodule

// ==== design/rv32i_pipeline.sv ====
`timescale 1ns/1ps

module rv32i_pipeline #(
    parameter rv32i_pkg::word_t RESET_PC = '0
) (
    input  logic                clk,
    input  logic                reset_i,
    output logic                inst_read_o,
    output rv32i_pkg::word_t    inst_addr_o,
    input  logic                inst_resp_i,
    input  rv32i_pkg::word_t    inst_rdata_i,
    output logic                retire_valid_o,
    output rv32i_pkg::word_t    retire_pc_o,
    output logic                retire_we_o,
    output rv32i_pkg::reg_idx_t retire_rd_o,
    output rv32i_pkg::word_t    retire_data_o
);
    import rv32i_pkg::*;

    logic     read_q;
    logic     advance;
    logic     flush;
    logic     redirect;
    logic     ex_redirect;
    word_t    pc;
    word_t    target;
    // IF/ID
    logic     id_valid;
    word_t    id_pc;
    word_t    id_instr;
    decoded_t id_dec;
    word_t    id_rs1_val;
    word_t    id_rs2_val;
    // ID/EX
    logic     ex_valid;
    word_t    ex_pc;
    decoded_t ex_dec;
    word_t    ex_rs1_val;
    word_t    ex_rs2_val;
    word_t    ex_op1;
    word_t    ex_op2;
    word_t    ex_alu_result;
    word_t    ex_result;
    // EX/MEM
    logic     mem_valid;
    word_t    mem_pc;
    decoded_t mem_dec;
    word_t    mem_result;
    // MEM/WB
    logic     wb_valid;
    word_t    wb_pc;
    decoded_t wb_dec;
    word_t    wb_result;

    assign inst_read_o = read_q;
    assign inst_addr_o = pc;
    // fetch response is the only thing that holds the pipe
    // nothing moves or retires while reset is high
    assign advance     = read_q & inst_resp_i & ~reset_i;
    assign redirect    = ex_valid & ex_redirect;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            read_q    <= 1'b0;
            id_valid  <= 1'b0;
            ex_valid  <= 1'b0;
            mem_valid <= 1'b0;
            wb_valid  <= 1'b0;
        end else begin
            read_q <= 1'b1;
            if (advance) begin
                // flushed slots become bubbles
                id_valid  <= ~flush;
                ex_valid  <= id_valid & ~flush;
                mem_valid <= ex_valid;
                wb_valid  <= mem_valid;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            id_pc      <= pc;
            id_instr   <= flush ? NOP_INSTR : inst_rdata_i;
            ex_pc      <= id_pc;
            ex_dec     <= id_dec;
            ex_rs1_val <= id_rs1_val;
            ex_rs2_val <= id_rs2_val;
            mem_pc     <= ex_pc;
            mem_dec    <= ex_dec;
            mem_result <= ex_result;
            wb_pc      <= mem_pc;
            wb_dec     <= mem_dec;
            wb_result  <= mem_result;
        end
    end

    rv32i_pc_control #(
        .RESET_PC(RESET_PC)
    ) pc_control_inst (
        .clk       (clk),
        .reset_i   (reset_i),
        .advance_i (advance),
        .redirect_i(redirect),
        .target_i  (target),
        .pc_o      (pc),
        .flush_o   (flush)
    );

    rv32i_decoder decoder_inst (
        .instr_i  (id_instr),
        .decoded_o(id_dec)
    );

    rv32i_regfile regfile_inst (
        .clk      (clk),
        .reset_i  (reset_i),
        .we_i     (advance & wb_valid & wb_dec.reg_write),
        .waddr_i  (wb_dec.rd),
        .wdata_i  (wb_result),
        .raddr_a_i(id_dec.rs1),
        .raddr_b_i(id_dec.rs2),
        .rdata_a_o(id_rs1_val),
        .rdata_b_o(id_rs2_val)
    );

    rv32i_forward forward_inst (
        .ex_rs1_i    (ex_dec.rs1),
        .ex_rs2_i    (ex_dec.rs2),
        .rs1_val_i   (ex_rs1_val),
        .rs2_val_i   (ex_rs2_val),
        .mem_rd_i    (mem_dec.rd),
        .mem_write_i (mem_valid & mem_dec.reg_write),
        .mem_result_i(mem_result),
        .wb_rd_i     (wb_dec.rd),
        .wb_write_i  (wb_valid & wb_dec.reg_write),
        .wb_result_i (wb_result),
        .op1_o       (ex_op1),
        .op2_o       (ex_op2)
    );

    rv32i_alu alu_inst (
        .decoded_i (ex_dec),
        .pc_i      (ex_pc),
        .op1_i     (ex_op1),
        .op2_i     (ex_op2),
        .result_o  (ex_alu_result),
        .target_o  (target),
        .redirect_o(ex_redirect)
    );

    // link value folded in here so MEM and WB forward the final value
    assign ex_result = (ex_dec.wb_sel == wb_pc4) ? ex_pc + 32'd4 : ex_alu_result;

    // retire report straight from MEM/WB
    assign retire_valid_o = advance & wb_valid;
    assign retire_pc_o    = wb_pc;
    assign retire_we_o    = wb_valid & wb_dec.reg_write;
    assign retire_rd_o    = wb_dec.rd;
    assign retire_data_o  = wb_result;

endmodule

// ==== testbench/rv32i_assert.sv ====
`timescale 1ns/1ps

module rv32i_assert (
    input logic                clk,
    input logic                reset_i,
    input logic                inst_read_i,
    input rv32i_pkg::word_t    inst_addr_i,
    input logic                inst_resp_i,
    input logic                retire_valid_i,
    input logic                retire_we_i,
    input rv32i_pkg::reg_idx_t retire_rd_i
);

    // no retire reported in any reset cycle
    retire_quiet_in_reset: assert property (@(posedge clk) reset_i |-> !retire_valid_i)
        else $error("retire_valid_o high during reset");

    // x0 never reported as written
    no_x0_write: assert property (@(posedge clk) retire_we_i |-> retire_rd_i != '0)
        else $error("retire_we_o high with retire_rd_o zero");

    // fetch address held until the response comes
    addr_stable_on_stall: assert property (@(posedge clk) disable iff (reset_i)
        inst_read_i && !inst_resp_i |=> $stable(inst_addr_i))
        else $error("inst_addr_o changed while a fetch was pending");

endmodule

bind rv32i_pipeline rv32i_assert assert_inst (
    .clk           (clk),
    .reset_i       (reset_i),
    .inst_read_i   (inst_read_o),
    .inst_addr_i   (inst_addr_o),
    .inst_resp_i   (inst_resp_i),
    .retire_valid_i(retire_valid_o),
    .retire_we_i   (retire_we_o),
    .retire_rd_i   (retire_rd_o)
);

// ==== include/rv32i_ref_model.svh ====
`ifndef RV32I_REF_MODEL_SVH
`define RV32I_REF_MODEL_SVH

// alu behaviour by funct3, alt selects sub or sra
function automatic rv32i_pkg::word_t ref_alu(input logic [2:0] f3, input logic alt,
                                            input rv32i_pkg::word_t a,
                                            input rv32i_pkg::word_t b);
    case (f3)
        3'b000:  return alt ? a - b : a + b;
        3'b001:  return a << b[4:0];
        3'b010:  return {31'b0, $signed(a) < $signed(b)};
        3'b011:  return {31'b0, a < b};
        3'b100:  return a ^ b;
        3'b101: begin
            if (alt) begin
                return $signed(a) >>> b[4:0];
            end
            return a >> b[4:0];
        end
        3'b110:  return a | b;
        default: return a & b;
    endcase
endfunction

// branch outcome by funct3
function automatic logic ref_taken(input logic [2:0] f3, input rv32i_pkg::word_t a,
                                   input rv32i_pkg::word_t b);
    case (f3)
        3'b000:  return a == b;
        3'b001:  return a != b;
        3'b100:  return $signed(a) < $signed(b);
        3'b101:  return $signed(a) >= $signed(b);
        3'b110:  return a < b;
        3'b111:  return a >= b;
        default: return 1'b0;
    endcase
endfunction

// one instruction step, data only meaningful when we is set
function automatic void ref_step(input rv32i_pkg::word_t instr, input rv32i_pkg::word_t pc,
                                 input rv32i_pkg::word_t rs1_val,
                                 input rv32i_pkg::word_t rs2_val,
                                 output rv32i_pkg::word_t next_pc, output logic we,
                                 output rv32i_pkg::reg_idx_t rd,
                                 output rv32i_pkg::word_t data);
    rv32i_pkg::word_t i_imm;
    rv32i_pkg::word_t b_imm;
    rv32i_pkg::word_t u_imm;
    rv32i_pkg::word_t j_imm;
    logic [2:0]       f3;
    i_imm   = {{20{instr[31]}}, instr[31:20]};
    b_imm   = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
    u_imm   = {instr[31:12], 12'b0};
    j_imm   = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
    f3      = instr[14:12];
    next_pc = pc + 32'd4;
    rd      = instr[11:7];
    we      = 1'b1;
    data    = '0;
    case (instr[6:0])
        rv32i_pkg::op_lui:   data = u_imm;
        rv32i_pkg::op_auipc: data = pc + u_imm;
        rv32i_pkg::op_jal: begin
            data    = pc + 32'd4;
            next_pc = pc + j_imm;
        end
        rv32i_pkg::op_jalr: begin
            data    = pc + 32'd4;
            next_pc = (rs1_val + i_imm) & ~32'd1;
        end
        rv32i_pkg::op_imm:   data = ref_alu(f3, f3 == 3'b101 && instr[30], rs1_val, i_imm);
        rv32i_pkg::op_reg:   data = ref_alu(f3, instr[30], rs1_val, rs2_val);
        rv32i_pkg::op_br: begin
            rd = '0;
            if (ref_taken(f3, rs1_val, rs2_val)) begin
                next_pc = pc + b_imm;
            end
        end
        default:             rd = '0;
    endcase
    we = we && rd != '0;
endfunction

`endif

// ==== testbench/rv32i_tb.sv ====
`timescale 1ns/1ps

module rv32i_tb;
    import rv32i_pkg::*;

    `include "rv32i_ref_model.svh"

    localparam int    CLK_PERIOD      = 100;
    localparam int    RESET_CYCLES    = 8;
    localparam int    IMEM_WORDS      = 64;
    localparam int    RETIRES         = 200;
    localparam int    NUM_TESTS       = 5;
    // four wait cycles per retire at worst, eight times over
    localparam int    WATCHDOG_CYCLES = NUM_TESTS * RETIRES * 4 * 8;
    localparam word_t RESET_PC        = 32'h0000_0100;
    // program flavours
    localparam int    MODE_ALU        = 0;
    localparam int    MODE_MIX        = 1;
    localparam int    MODE_X0         = 2;

    logic        clk;
    logic        reset_i;
    logic        inst_read_o;
    word_t       inst_addr_o;
    logic        inst_resp_i;
    word_t       inst_rdata_i;
    logic        retire_valid_o;
    word_t       retire_pc_o;
    logic        retire_we_o;
    reg_idx_t    retire_rd_o;
    word_t       retire_data_o;

    word_t       imem [IMEM_WORDS];
    word_t       ref_regs [32];
    word_t       ref_pc;
    int          seed;
    int          max_wait;
    int          wait_left;
    int          retire_count;
    int          errors;
    int          errors_mark;
    int          checks;
    int          tests_done;
    logic        fetch_seen;
    // per-run retire trace, {we, rd, data} in the second queue
    word_t       trace_pc [$];
    logic [37:0] trace_wb [$];
    word_t       base_pc [$];
    logic [37:0] base_wb [$];

    rv32i_pipeline #(
        .RESET_PC(RESET_PC)
    ) rv32i_pipeline_inst (
        .clk           (clk),
        .reset_i       (reset_i),
        .inst_read_o   (inst_read_o),
        .inst_addr_o   (inst_addr_o),
        .inst_resp_i   (inst_resp_i),
        .inst_rdata_i  (inst_rdata_i),
        .retire_valid_o(retire_valid_o),
        .retire_pc_o   (retire_pc_o),
        .retire_we_o   (retire_we_o),
        .retire_rd_o   (retire_rd_o),
        .retire_data_o (retire_data_o)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic int rand_below(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    // standard RV32I encodings
    function automatic word_t rtype_word(input logic [6:0] f7, input reg_idx_t rs2,
                                         input reg_idx_t rs1, input logic [2:0] f3,
                                         input reg_idx_t rd);
        return {f7, rs2, rs1, f3, rd, op_reg};
    endfunction

    function automatic word_t itype_word(input logic [11:0] imm, input reg_idx_t rs1,
                                         input logic [2:0] f3, input reg_idx_t rd,
                                         input logic [6:0] opcode);
        return {imm, rs1, f3, rd, opcode};
    endfunction

    function automatic word_t utype_word(input logic [19:0] imm, input reg_idx_t rd,
                                         input logic [6:0] opcode);
        return {imm, rd, opcode};
    endfunction

    function automatic word_t branch_word(input logic [12:0] off, input reg_idx_t rs2,
                                          input reg_idx_t rs1, input logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], op_br};
    endfunction

    function automatic word_t jal_word(input logic [20:0] off, input reg_idx_t rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, op_jal};
    endfunction

    // x0..x4 only so hazards show up all the time
    function automatic word_t random_instr(input int idx, input int mode);
        reg_idx_t    rd;
        reg_idx_t    rs1;
        reg_idx_t    rs2;
        logic [2:0]  f3;
        logic [11:0] imm;
        logic [6:0]  f7;
        int          hop;
        rd  = reg_idx_t'(rand_below(5));
        rs1 = reg_idx_t'(rand_below(5));
        rs2 = reg_idx_t'(rand_below(5));
        f3  = 3'(rand_below(8));
        imm = 12'($random(seed));
        hop = 4 * (1 + rand_below(4));
        f7  = 7'h00;
        if (mode == MODE_X0 && rand_below(2) == 0) begin
            rd = '0;
        end
        case (rand_below(mode == MODE_ALU ? 4 : 8))
            0: begin
                // sub and sra variants
                if ((f3 == 3'b000 || f3 == 3'b101) && rand_below(2) == 1) begin
                    f7 = 7'h20;
                end
                return rtype_word(f7, rs2, rs1, f3, rd);
            end
            1: begin
                // shift immediates keep the upper bits legal
                if (f3 == 3'b001) begin
                    imm[11:5] = 7'h00;
                end
                if (f3 == 3'b101) begin
                    imm[11:5] = rand_below(2) == 1 ? 7'h20 : 7'h00;
                end
                return itype_word(imm, rs1, f3, rd, op_imm);
            end
            2: return utype_word(20'($random(seed)), rd, op_lui);
            3: return utype_word(20'($random(seed)), rd, op_auipc);
            4, 5: begin
                // 0,1,2..5 onto beq,bne,blt..bgeu
                f3 = 3'(rand_below(6));
                if (f3 >= 3'd2) begin
                    f3 = f3 + 3'd2;
                end
                return branch_word(13'(hop), rs2, rs1, f3);
            end
            6: return jal_word(21'(hop), rd);
            default: begin
                // absolute word target a few slots ahead, through x0
                imm = 12'(((idx + 1 + rand_below(4)) % IMEM_WORDS) * 4);
                return itype_word(imm, 5'd0, 3'b000, rd, op_jalr);
            end
        endcase
    endfunction

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        checks++;
        if (expected !== actual) begin
            $display("[FAIL] %s expected %0h actual %0h", name, expected, actual);
            errors++;
        end
    endtask

    // reset held for RESET_CYCLES edges, model and program set up meanwhile
    task automatic start_run(input int wait_limit, input logic new_program, input int mode);
        @(posedge clk);
        reset_i <= 1'b1;
        @(negedge clk);
        max_wait     = wait_limit;
        ref_pc       = RESET_PC;
        retire_count = 0;
        for (int i = 0; i < 32; i++) begin
            ref_regs[i] = '0;
        end
        trace_pc.delete();
        trace_wb.delete();
        if (new_program) begin
            for (int i = 0; i < IMEM_WORDS; i++) begin
                imem[i] = random_instr(i, mode);
            end
        end
        repeat (RESET_CYCLES) @(posedge clk);
        reset_i <= 1'b0;
    endtask

    task automatic wait_retires(input int n);
        while (retire_count < n) begin
            @(negedge clk);
        end
    endtask

    task automatic finish_test(input string name);
        tests_done++;
        $display("test %s done, %0d retires, %0d errors", name, retire_count,
                 errors - errors_mark);
        errors_mark = errors;
    endtask

    // instruction memory, response after 0..max_wait idle cycles
    always @(posedge clk) begin
        if (reset_i) begin
            inst_resp_i <= 1'b0;
            wait_left = rand_below(max_wait + 1);
        end else if (inst_read_o && inst_resp_i) begin
            inst_resp_i <= 1'b0;
            wait_left = rand_below(max_wait + 1);
        end else if (inst_read_o) begin
            if (wait_left == 0) begin
                inst_resp_i  <= 1'b1;
                inst_rdata_i <= imem[(inst_addr_o >> 2) % IMEM_WORDS];
            end else begin
                wait_left--;
            end
        end
    end

    // every retire checked against the next model step
    always @(posedge clk) begin : retire_monitor
        word_t    instr;
        word_t    next_pc;
        word_t    data;
        logic     we;
        reg_idx_t rd;
        if (reset_i) begin
            fetch_seen = 1'b0;
        end else begin
            if (retire_valid_o && !fetch_seen) begin
                $display("retire seen at pc %0h before the first fetch", retire_pc_o);
                errors++;
            end
            if (inst_read_o && !fetch_seen) begin
                check_value("inst_addr_o", RESET_PC, inst_addr_o);
                fetch_seen = 1'b1;
            end
            if (retire_valid_o) begin
                instr = imem[(ref_pc >> 2) % IMEM_WORDS];
                ref_step(instr, ref_pc, ref_regs[instr[19:15]], ref_regs[instr[24:20]],
                         next_pc, we, rd, data);
                check_value("retire_pc_o", ref_pc, retire_pc_o);
                check_value("retire_we_o", we, retire_we_o);
                check_value("retire_rd_o", rd, retire_rd_o);
                if (we) begin
                    check_value("retire_data_o", data, retire_data_o);
                    ref_regs[rd] = data;
                end
                trace_pc.push_back(retire_pc_o);
                trace_wb.push_back({retire_we_o, retire_rd_o,
                                    retire_we_o ? retire_data_o : 32'h0});
                ref_pc = next_pc;
                retire_count++;
            end
        end
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("watchdog expired after %0d clock cycles with tests unfinished",
                 WATCHDOG_CYCLES);
        $display("Errors found");
        $finish;
    end

    initial begin
        clk          = 1'b0;
        reset_i      = 1'b1;
        inst_resp_i  = 1'b0;
        inst_rdata_i = NOP_INSTR;
        seed         = 99128;
        max_wait     = 0;
        wait_left    = 0;
        retire_count = 0;
        errors       = 0;
        errors_mark  = 0;
        checks       = 0;
        tests_done   = 0;
        fetch_seen   = 1'b0;
        ref_pc       = RESET_PC;

        // first fetch address and no early retire
        start_run(0, 1'b1, MODE_ALU);
        while (!fetch_seen) begin
            @(negedge clk);
        end
        check_value("retire count at first fetch", 0, retire_count);
        finish_test("reset");

        // dependent alu streams exercise MEM, WB and regfile bypass
        start_run(0, 1'b1, MODE_ALU);
        wait_retires(RETIRES);
        finish_test("alu");

        start_run(0, 1'b1, MODE_MIX);
        wait_retires(RETIRES);
        finish_test("branch");

        start_run(0, 1'b1, MODE_X0);
        wait_retires(RETIRES);
        finish_test("x0");

        // same program without and with fetch wait states
        start_run(0, 1'b1, MODE_MIX);
        wait_retires(RETIRES);
        base_pc = trace_pc;
        base_wb = trace_wb;
        start_run(3, 1'b0, MODE_MIX);
        wait_retires(RETIRES);
        for (int i = 0; i < RETIRES; i++) begin
            check_value("stalled retire_pc_o", base_pc[i], trace_pc[i]);
            check_value("stalled retire we/rd/data", base_wb[i], trace_wb[i]);
        end
        finish_test("stall");

        $display("summary: %0d tests, %0d checks, %0d errors", tests_done, checks, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// ==== build.f ====
+incdir+include
design/rv32i_pkg.sv
design/rv32i_decoder.sv
design/rv32i_regfile.sv
design/rv32i_alu.sv
design/rv32i_forward.sv
design/rv32i_pc_control.sv
design/rv32i_pipeline.sv
testbench/rv32i_assert.sv
testbench/rv32i_tb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f build.f --top-module rv32i_tb -o rv32i_sim

out=$(./obj_dir/rv32i_sim) || true
printf '%s\n' "$out"

# pass only if the testbench printed its pass line
printf '%s\n' "$out" | grep -qx "No errors"
